//--- common/loader_pkg.sv
// ROM map, download stream indices and data-width types for the loader
`default_nettype none

package loader_pkg;

	// ==================================================
	// Data widths
	// ==================================================

	typedef logic [7:0] byte_t;

	// Byte address in the ROM store
	typedef logic [11:0] rom_addr_t;

	// Offset inside one half of the ROM
	typedef logic [10:0] region_addr_t;

	// Host download address and stream tag
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [7:0] ioctl_index_t;

	// ==================================================
	// ROM map
	// ==================================================

	localparam int rom_bytes = 4096;

	// CPU region starts at 0, graphics in the upper half
	localparam rom_addr_t gfx_base = 12'd2048;

	// ==================================================
	// Download indices
	// ==================================================

	localparam ioctl_index_t index_rom = 8'd0;
	localparam ioctl_index_t index_variant = 8'd1;
	localparam ioctl_index_t index_dip = 8'd254;

	// Number of DIP switch bytes kept
	localparam int dip_count = 2;

endpackage

`default_nettype wire

//--- common/control_pkg.sv
// Reset and pause timing constants, hardware variant codes and pixel types
`default_nettype none

package control_pkg;

	// Core reset hold after the ROM is loaded
	typedef logic [7:0] reset_count_t;
	localparam reset_count_t reset_hold_cycles = 8'd32;

	// Pause timer, dims the screen once it saturates
	typedef logic [15:0] pause_timer_t;
	localparam pause_timer_t pause_dim_cycles = 16'd200;

	// ==================================================
	// Pixel types
	// ==================================================

	typedef logic [3:0] channel_t;

	// Red in the top bits, then green, then blue
	typedef logic [11:0] rgb_t;

	// Hardware variant byte and the codes that change orientation
	typedef logic [7:0] variant_t;
	localparam variant_t variant_portrait = 8'h06;
	localparam variant_t variant_portrait_ccw = 8'h0B;

endpackage

`default_nettype wire

//--- common/rom_bus_if.sv
// ROM read port interface with requester and arbiter modports
`default_nettype none
`timescale 1ns/1ps

interface rom_bus_if;

	// Request held with a stable address until ack
	logic req;
	loader_pkg::region_addr_t addr;

	// One-cycle ack, data valid in the same cycle
	logic ack;
	loader_pkg::byte_t data;

	modport requester (
		output req,
		output addr,
		input ack,
		input data
	);

	modport arbiter (
		input req,
		input addr,
		output ack,
		output data
	);

endinterface

`default_nettype wire

//--- download/download_decoder.sv
// Host download decoder: ROM writes, variant register and decode, DIP bytes, ROM-loaded flag
`default_nettype none
`timescale 1ns/1ps

module download_decoder (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic ioctl_download,
	input wire loader_pkg::ioctl_index_t ioctl_index,
	input wire logic ioctl_wr,
	input wire loader_pkg::ioctl_addr_t ioctl_addr,
	input wire loader_pkg::byte_t ioctl_dout,
	output logic rom_wr,
	output loader_pkg::rom_addr_t rom_wr_addr,
	output loader_pkg::byte_t rom_wr_data,
	output logic rom_loaded,
	output control_pkg::variant_t core_mod,
	output logic landscape,
	output logic rotate_ccw,
	output loader_pkg::byte_t dip_sw0,
	output loader_pkg::byte_t dip_sw1
);

	logic rom_download;
	logic rom_download_d;
	logic rom_hit;
	logic dip_hit;

	assign rom_download = ioctl_download && (ioctl_index == loader_pkg::index_rom);

	// Only bytes that fit the store become writes
	assign rom_hit = ioctl_wr && (ioctl_index == loader_pkg::index_rom) &&
		(ioctl_addr < loader_pkg::ioctl_addr_t'(loader_pkg::rom_bytes));

	assign dip_hit = ioctl_wr && (ioctl_index == loader_pkg::index_dip) &&
		(ioctl_addr < loader_pkg::ioctl_addr_t'(loader_pkg::dip_count));

	// ==================================================
	// Control registers
	// ==================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_wr <= 1'b0;
			rom_download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_mod <= '0;
			dip_sw0 <= '0;
			dip_sw1 <= '0;
		end else begin
			rom_wr <= rom_hit;
			rom_download_d <= rom_download;
			// Falling edge of a ROM download marks the image complete
			if (rom_download_d && !rom_download) begin
				rom_loaded <= 1'b1;
			end
			if (ioctl_wr && (ioctl_index == loader_pkg::index_variant)) begin
				core_mod <= ioctl_dout;
			end
			if (dip_hit) begin
				if (ioctl_addr[0]) begin
					dip_sw1 <= ioctl_dout;
				end else begin
					dip_sw0 <= ioctl_dout;
				end
			end
		end
	end

	// Write payload, only sampled when the write strobe is set
	always_ff @(posedge clk_sys) begin
		if (rom_hit) begin
			rom_wr_addr <= loader_pkg::rom_addr_t'(ioctl_addr);
			rom_wr_data <= ioctl_dout;
		end
	end

	// Variant decode into screen orientation
	always_comb begin
		landscape = 1'b1;
		rotate_ccw = 1'b0;
		case (core_mod)
			control_pkg::variant_portrait: begin
				landscape = 1'b0;
			end
			control_pkg::variant_portrait_ccw: begin
				landscape = 1'b0;
				rotate_ccw = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rom/rom_store.sv
// Single-port game ROM store with synchronous write and registered read
`default_nettype none
`timescale 1ns/1ps

module rom_store (
	input wire logic clk_sys,
	input wire logic we,
	input wire loader_pkg::rom_addr_t addr,
	input wire loader_pkg::byte_t wdata,
	output loader_pkg::byte_t rdata
);

	loader_pkg::byte_t mem [loader_pkg::rom_bytes];

	// Read returns the old contents on a write cycle
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- rom/rom_arbiter.sv
// ROM store arbiter: download writes first, then alternating CPU and graphics reads
`default_nettype none
`timescale 1ns/1ps

module rom_arbiter (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic rom_wr,
	input wire loader_pkg::rom_addr_t rom_wr_addr,
	input wire loader_pkg::byte_t rom_wr_data,
	rom_bus_if.arbiter cpu_bus,
	rom_bus_if.arbiter gfx_bus,
	output logic mem_we,
	output loader_pkg::rom_addr_t mem_addr,
	output loader_pkg::byte_t mem_wdata,
	input wire loader_pkg::byte_t mem_rdata
);

	// Set for the cycle after a grant, while the store returns data
	logic cpu_pend;
	logic gfx_pend;
	logic last_gfx;
	logic cpu_wait;
	logic gfx_wait;
	logic cpu_grant;
	logic gfx_grant;

	// A port in flight keeps its req up during ack, so mask it
	assign cpu_wait = cpu_bus.req && !cpu_pend;
	assign gfx_wait = gfx_bus.req && !gfx_pend;

	// ==================================================
	// Grant selection
	// ==================================================

	always_comb begin
		cpu_grant = 1'b0;
		gfx_grant = 1'b0;
		if (!rom_wr) begin
			if (cpu_wait && gfx_wait) begin
				cpu_grant = last_gfx;
				gfx_grant = !last_gfx;
			end else begin
				cpu_grant = cpu_wait;
				gfx_grant = gfx_wait;
			end
		end
	end

	// Store address, graphics offsets sit above gfx_base
	always_comb begin
		if (rom_wr) begin
			mem_addr = rom_wr_addr;
		end else if (gfx_grant) begin
			mem_addr = loader_pkg::gfx_base + loader_pkg::rom_addr_t'(gfx_bus.addr);
		end else begin
			mem_addr = loader_pkg::rom_addr_t'(cpu_bus.addr);
		end
	end

	assign mem_we = rom_wr;
	assign mem_wdata = rom_wr_data;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cpu_pend <= 1'b0;
			gfx_pend <= 1'b0;
			last_gfx <= 1'b0;
		end else begin
			cpu_pend <= cpu_grant;
			gfx_pend <= gfx_grant;
			if (cpu_grant || gfx_grant) begin
				last_gfx <= gfx_grant;
			end
		end
	end

	// Returning store data goes to whichever port was granted
	assign cpu_bus.ack = cpu_pend;
	assign cpu_bus.data = cpu_pend ? mem_rdata : '0;
	assign gfx_bus.ack = gfx_pend;
	assign gfx_bus.data = gfx_pend ? mem_rdata : '0;

endmodule

`default_nettype wire

//--- source/reset_pause_ctrl.sv
// Core reset counter, pause toggle and timer, and the RGB dim path
`default_nettype none
`timescale 1ns/1ps

module reset_pause_ctrl (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic rom_loaded,
	input wire logic reset_button,
	input wire logic pause_button,
	input wire logic osd_open,
	input wire logic pause_on_osd,
	input wire control_pkg::rgb_t rgb_in,
	output logic core_reset,
	output logic pause,
	output control_pkg::rgb_t rgb_out
);

	control_pkg::reset_count_t reset_count;
	control_pkg::pause_timer_t pause_timer;
	logic pause_button_d;
	logic pause_toggle;
	logic toggle_next;
	logic dim_video;
	control_pkg::channel_t red;
	control_pkg::channel_t green;
	control_pkg::channel_t blue;

	// ==================================================
	// Core reset
	// ==================================================

	// Held in reload until the ROM is in and the button is released
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			reset_count <= control_pkg::reset_hold_cycles;
		end else if (reset_button || !rom_loaded) begin
			reset_count <= control_pkg::reset_hold_cycles;
		end else if (reset_count != '0) begin
			reset_count <= reset_count - 1'b1;
		end
	end

	assign core_reset = (reset_count != '0);

	// ==================================================
	// Pause
	// ==================================================

	assign toggle_next = pause_toggle ^ (pause_button && !pause_button_d);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pause_button_d <= 1'b0;
			pause_toggle <= 1'b0;
			pause <= 1'b0;
		end else begin
			pause_button_d <= pause_button;
			pause_toggle <= toggle_next;
			pause <= toggle_next || (osd_open && pause_on_osd);
		end
	end

	// Time spent paused, saturating at the dim point
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pause_timer <= '0;
		end else if (!pause) begin
			pause_timer <= '0;
		end else if (pause_timer < control_pkg::pause_dim_cycles) begin
			pause_timer <= pause_timer + 1'b1;
		end
	end

	assign dim_video = (pause_timer >= control_pkg::pause_dim_cycles);

	// Dim halves every channel
	assign red = rgb_in[11:8];
	assign green = rgb_in[7:4];
	assign blue = rgb_in[3:0];

	always_comb begin
		if (dim_video) begin
			rgb_out = {red >> 1, green >> 1, blue >> 1};
		end else begin
			rgb_out = rgb_in;
		end
	end

endmodule

`default_nettype wire

//--- source/irem_loader_top.sv
// Loader top level: download decoder, ROM arbiter, ROM store and reset/pause control
`default_nettype none
`timescale 1ns/1ps

module irem_loader_top (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic ioctl_download,
	input wire loader_pkg::ioctl_index_t ioctl_index,
	input wire logic ioctl_wr,
	input wire loader_pkg::ioctl_addr_t ioctl_addr,
	input wire loader_pkg::byte_t ioctl_dout,
	input wire logic reset_button,
	input wire logic pause_button,
	input wire logic osd_open,
	input wire logic pause_on_osd,
	input wire logic cpu_req,
	input wire loader_pkg::region_addr_t cpu_addr,
	output logic cpu_ack,
	output loader_pkg::byte_t cpu_data,
	input wire logic gfx_req,
	input wire loader_pkg::region_addr_t gfx_addr,
	output logic gfx_ack,
	output loader_pkg::byte_t gfx_data,
	input wire control_pkg::rgb_t rgb_in,
	output control_pkg::rgb_t rgb_out,
	output logic core_reset,
	output logic pause,
	output logic rom_loaded,
	output control_pkg::variant_t core_mod,
	output logic landscape,
	output logic rotate_ccw,
	output loader_pkg::byte_t dip_sw0,
	output loader_pkg::byte_t dip_sw1
);

	logic rom_wr;
	loader_pkg::rom_addr_t rom_wr_addr;
	loader_pkg::byte_t rom_wr_data;
	logic mem_we;
	loader_pkg::rom_addr_t mem_addr;
	loader_pkg::byte_t mem_wdata;
	loader_pkg::byte_t mem_rdata;

	rom_bus_if cpu_bus ();
	rom_bus_if gfx_bus ();

	// Read ports map one-to-one onto the top-level pins
	assign cpu_bus.req = cpu_req;
	assign cpu_bus.addr = cpu_addr;
	assign cpu_ack = cpu_bus.ack;
	assign cpu_data = cpu_bus.data;
	assign gfx_bus.req = gfx_req;
	assign gfx_bus.addr = gfx_addr;
	assign gfx_ack = gfx_bus.ack;
	assign gfx_data = gfx_bus.data;

	download_decoder download_decoder_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.rom_wr(rom_wr),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.rom_loaded(rom_loaded),
		.core_mod(core_mod),
		.landscape(landscape),
		.rotate_ccw(rotate_ccw),
		.dip_sw0(dip_sw0),
		.dip_sw1(dip_sw1)
	);

	rom_arbiter rom_arbiter_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.rom_wr(rom_wr),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.cpu_bus(cpu_bus.arbiter),
		.gfx_bus(gfx_bus.arbiter),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	rom_store rom_store_i (
		.clk_sys(clk_sys),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	reset_pause_ctrl reset_pause_ctrl_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.rom_loaded(rom_loaded),
		.reset_button(reset_button),
		.pause_button(pause_button),
		.osd_open(osd_open),
		.pause_on_osd(pause_on_osd),
		.rgb_in(rgb_in),
		.core_reset(core_reset),
		.pause(pause),
		.rgb_out(rgb_out)
	);

endmodule

`default_nettype wire

//--- tests/loader_check_tasks.svh
// Compare tasks for bytes, pixels and flags, and the failure reporting helper
`ifndef loader_check_tasks_svh
`define loader_check_tasks_svh

// ==================================================
// Failure reporting
// ==================================================

// Prints the reason and ends the run at the first error
task automatic stop_with_error(input string reason);
	error_count++;
	$display("%s", reason);
	$display("TEST FAIL");
	$fatal(1, "Simulation stopped at %0t", $time);
endtask

// ==================================================
// Compare tasks
// ==================================================

task automatic check_byte(input string test_name, input loader_pkg::byte_t expected,
	input loader_pkg::byte_t actual);
	if (actual !== expected) begin
		stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
			test_name, expected, actual));
	end
endtask

// Pixel compare, shown as three hex digits
task automatic check_rgb(input string test_name, input control_pkg::rgb_t expected,
	input control_pkg::rgb_t actual);
	if (actual !== expected) begin
		stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
			test_name, expected, actual));
	end
endtask

task automatic check_flag(input string test_name, input logic expected,
	input logic actual);
	if (actual !== expected) begin
		stop_with_error($sformatf("CHECK FAILED %s expected %b actual %b",
			test_name, expected, actual));
	end
endtask

`endif

//--- tests/irem_loader_tb.sv
// Loader testbench: clock and reset, stimulus file reader, ROM read requesters and timeout
`default_nettype none
`timescale 1ns/1ps

module irem_loader_tb;

	logic clk_sys;
	logic rst_n;
	logic ioctl_download;
	loader_pkg::ioctl_index_t ioctl_index;
	logic ioctl_wr;
	loader_pkg::ioctl_addr_t ioctl_addr;
	loader_pkg::byte_t ioctl_dout;
	logic reset_button;
	logic pause_button;
	logic osd_open;
	logic pause_on_osd;
	logic cpu_req;
	loader_pkg::region_addr_t cpu_addr;
	logic cpu_ack;
	loader_pkg::byte_t cpu_data;
	logic gfx_req;
	loader_pkg::region_addr_t gfx_addr;
	logic gfx_ack;
	loader_pkg::byte_t gfx_data;
	control_pkg::rgb_t rgb_in;
	control_pkg::rgb_t rgb_out;
	logic core_reset;
	logic pause;
	logic rom_loaded;
	control_pkg::variant_t core_mod;
	logic landscape;
	logic rotate_ccw;
	loader_pkg::byte_t dip_sw0;
	loader_pkg::byte_t dip_sw1;

	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	integer seed = 40;
	string actions[$];

	`include "loader_check_tasks.svh"

	irem_loader_top irem_loader_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	// Limit is armed once the stimulus length is known
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			stop_with_error($sformatf("Timeout after %0d cycles, the DUT stopped responding",
				cycle_count));
		end
	end

	// ==================================================
	// Host and requester tasks
	// ==================================================

	// One write pulse, then an idle cycle before the next
	task automatic host_write(input loader_pkg::ioctl_index_t index,
		input loader_pkg::ioctl_addr_t addr, input loader_pkg::byte_t data);
		@(posedge clk_sys);
		ioctl_index <= index;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Request held until ack, data checked in the ack cycle
	task automatic read_rom_port(input logic use_gfx, input loader_pkg::region_addr_t offset,
		input loader_pkg::byte_t expected);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk_sys);
		@(posedge clk_sys);
		if (use_gfx) begin
			gfx_req <= 1'b1;
			gfx_addr <= offset;
		end else begin
			cpu_req <= 1'b1;
			cpu_addr <= offset;
		end
		@(negedge clk_sys);
		while (!(use_gfx ? gfx_ack : cpu_ack)) begin
			@(negedge clk_sys);
		end
		if (use_gfx) begin
			check_byte($sformatf("gfx read %03h", offset), expected, gfx_data);
		end else begin
			check_byte($sformatf("cpu read %03h", offset), expected, cpu_data);
		end
		@(posedge clk_sys);
		if (use_gfx) begin
			gfx_req <= 1'b0;
		end else begin
			cpu_req <= 1'b0;
		end
	endtask

	task automatic run_action(input byte cmd, input logic [31:0] f0, input logic [31:0] f1,
		input logic [31:0] f2, input logic [31:0] f3);
		case (cmd)
			"L": begin
				@(posedge clk_sys);
				ioctl_index <= loader_pkg::index_rom;
				ioctl_download <= 1'b1;
			end
			"D": begin
				host_write(loader_pkg::index_rom, loader_pkg::ioctl_addr_t'(f0),
					loader_pkg::byte_t'(f1));
				check_flag("core_reset held during download", 1'b1, core_reset);
				check_flag("rom_loaded low during download", 1'b0, rom_loaded);
			end
			"E": begin
				@(posedge clk_sys);
				ioctl_download <= 1'b0;
				@(negedge clk_sys);
				while (!rom_loaded) begin
					@(negedge clk_sys);
				end
				// Reset stays up for the hold count after the load completes
				check_flag("core_reset held after load", 1'b1, core_reset);
				while (core_reset) begin
					@(negedge clk_sys);
				end
			end
			"C": read_rom_port(1'b0, loader_pkg::region_addr_t'(f0), loader_pkg::byte_t'(f1));
			"G": read_rom_port(1'b1, loader_pkg::region_addr_t'(f0), loader_pkg::byte_t'(f1));
			"P": begin
				// Both ports compete for the store
				fork
					read_rom_port(1'b0, loader_pkg::region_addr_t'(f0), loader_pkg::byte_t'(f1));
					read_rom_port(1'b1, loader_pkg::region_addr_t'(f2), loader_pkg::byte_t'(f3));
				join
			end
			"V": begin
				host_write(loader_pkg::index_variant, '0, loader_pkg::byte_t'(f0));
				check_byte($sformatf("core_mod for variant %h", f0[7:0]), f0[7:0], core_mod);
				check_flag($sformatf("landscape for variant %h", f0[7:0]), f1[0], landscape);
				check_flag($sformatf("rotate_ccw for variant %h", f0[7:0]), f2[0], rotate_ccw);
			end
			"S": begin
				host_write(loader_pkg::index_dip, loader_pkg::ioctl_addr_t'(f0),
					loader_pkg::byte_t'(f1));
				check_byte($sformatf("dip_sw0 after write at %0h", f0), f2[7:0], dip_sw0);
				check_byte($sformatf("dip_sw1 after write at %0h", f0), f3[7:0], dip_sw1);
			end
			"U": begin
				@(posedge clk_sys);
				pause_button <= 1'b1;
				@(posedge clk_sys);
				pause_button <= 1'b0;
				repeat (2) @(negedge clk_sys);
				check_flag("pause after button pulse", f0[0], pause);
			end
			"O": begin
				@(posedge clk_sys);
				osd_open <= f0[0];
				pause_on_osd <= f1[0];
				repeat (2) @(negedge clk_sys);
				check_flag("pause with OSD setting", f2[0], pause);
			end
			"M": begin
				@(posedge clk_sys);
				rgb_in <= control_pkg::rgb_t'(f0);
				repeat (f1) @(negedge clk_sys);
				check_rgb($sformatf("rgb_out after %0d cycles", f1), control_pkg::rgb_t'(f2),
					rgb_out);
			end
			"R": begin
				@(posedge clk_sys);
				reset_button <= 1'b1;
				@(posedge clk_sys);
				reset_button <= 1'b0;
				@(negedge clk_sys);
				check_flag("core_reset on reset button", 1'b1, core_reset);
				while (core_reset) begin
					@(negedge clk_sys);
				end
			end
			default: stop_with_error($sformatf("Unknown stimulus action '%c'", cmd));
		endcase
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int fd;
		string line;
		byte cmd;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;

		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		reset_button = 1'b0;
		pause_button = 1'b0;
		osd_open = 1'b0;
		pause_on_osd = 1'b0;
		cpu_req = 1'b0;
		cpu_addr = '0;
		gfx_req = 1'b0;
		gfx_addr = '0;
		rgb_in = '0;

		fd = $fopen("tests/loader_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_error("Could not open the stimulus file tests/loader_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
				actions.push_back(line);
			end
		end
		$fclose(fd);
		cycle_limit = actions.size() * 20 + int'(control_pkg::pause_dim_cycles) +
			int'(control_pkg::reset_hold_cycles);

		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_flag("core_reset after reset", 1'b1, core_reset);
		check_flag("landscape after reset", 1'b1, landscape);
		check_flag("rom_loaded after reset", 1'b0, rom_loaded);
		check_flag("pause after reset", 1'b0, pause);

		foreach (actions[i]) begin
			cmd = actions[i].getc(0);
			f0 = '0;
			f1 = '0;
			f2 = '0;
			f3 = '0;
			void'($sscanf(actions[i].substr(1, actions[i].len() - 1), "%h %h %h %h",
				f0, f1, f2, f3));
			run_action(cmd, f0, f1, f2, f3);
		end

		repeat (2) @(negedge clk_sys);
		if (error_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

endmodule

`default_nettype wire

//--- irem_loader.f
+incdir+tests
common/loader_pkg.sv
common/control_pkg.sv
common/rom_bus_if.sv
download/download_decoder.sv
rom/rom_store.sv
rom/rom_arbiter.sv
source/reset_pause_ctrl.sv
source/irem_loader_top.sv
tests/irem_loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -Wno-fatal --top-module irem_loader_tb -f irem_loader.f \
	&& ./obj_dir/Virem_loader_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "TEST PASS" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tests/loader_stimulus.txt
# Action then hex fields: L/E ROM download start/end, D addr data, C/G offset byte, P cpu_off byte gfx_off byte
# V variant landscape rotate, S addr value sw0 sw1, U pause, O osd on_osd pause, M rgb_in cycles rgb_out, R
L
D 000 3c
D 005 a7
D 7ff 11
D 800 c4
D 80a 5e
D fff 92
E
C 000 3c
C 7ff 11
G 00a 5e
G 7ff 92
P 005 a7 000 c4
P 7ff 11 00a 5e
V 06 0 0
V 0b 0 1
V 42 1 0
S 0 5a 5a 00
S 1 c3 5a c3
S 5 ff 5a c3
U 1
U 0
O 1 1 1
M abc d8 556
O 0 0 0
M abc 2 abc
R
